//--- include/platform_config.svh
`ifndef PLATFORM_CONFIG_SVH
`define PLATFORM_CONFIG_SVH

// On-chip RAM depth in 32-bit words.
`define PLAT_RAM_WORDS 1024

// Region select, taken from word address bits 29 and 28. Region 3 is unmapped.
`define PLAT_REGION_RAM   2'd0
`define PLAT_REGION_PIO   2'd1
`define PLAT_REGION_TIMER 2'd2

// LED port register offsets.
`define PIO_OFF_DATA 2'd0
`define PIO_OFF_SET  2'd1
`define PIO_OFF_CLR  2'd2

// Interval timer register offsets.
`define TMR_OFF_LOAD   2'd0
`define TMR_OFF_CTRL   2'd1
`define TMR_OFF_STATUS 2'd2
`define TMR_OFF_COUNT  2'd3

// Timer control and status bit positions.
`define TMR_CTRL_EN        0
`define TMR_CTRL_IRQ_EN    1
`define TMR_STATUS_EXPIRED 0

`endif

//--- src/platform_pkg.sv
package platform_pkg;

	// One data word on the core bus.
	typedef logic [31:0] word_t;

	// Word address as issued by the core.
	typedef logic [29:0] addr_t;

	// Register offset inside a peripheral.
	typedef logic [1:0] reg_off_t;

	// LED output value.
	typedef logic [7:0] led_t;

	// Decoder is either free or has a request out at one target.
	typedef enum logic {
		DEC_IDLE,
		DEC_WAIT
	} dec_state_t;

endpackage

//--- src/bus_if.sv
`timescale 1ns/100ps

interface bus_if
	import platform_pkg::*;
();

	addr_t addr;
	word_t data_wr;
	logic  write;
	logic  start;
	word_t data_rd;
	logic  ready;

	modport decoder (
		output addr,
		output data_wr,
		output write,
		output start,
		input  data_rd,
		input  ready
	);

	modport target (
		input  addr,
		input  data_wr,
		input  write,
		input  start,
		output data_rd,
		output ready
	);

endinterface

//--- src/bus_decoder.sv
`timescale 1ns/100ps

`include "platform_config.svh"

module bus_decoder
	import platform_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  addr_t  addr,
	input  word_t  data_wr,
	input  logic   write,
	input  logic   start,
	output word_t  data_rd,
	output logic   ready,
	bus_if.decoder ram_bus,
	bus_if.decoder pio_bus,
	bus_if.decoder tmr_bus
);

	dec_state_t state;

	addr_t      addr_q;
	word_t      data_q;
	logic       write_q;
	logic [1:0] region_q;

	logic issue;
	logic unmapped;
	logic miss_ready;

	assign unmapped = region_q != `PLAT_REGION_RAM
	               && region_q != `PLAT_REGION_PIO
	               && region_q != `PLAT_REGION_TIMER;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= DEC_IDLE;
			issue      <= 1'b0;
			miss_ready <= 1'b0;
		end else begin
			issue      <= 1'b0;
			// Nobody answers an unmapped region, so the decoder answers itself.
			miss_ready <= issue && unmapped;

			case (state)
				DEC_IDLE:
					if (start) begin
						state <= DEC_WAIT;
						issue <= 1'b1;
					end

				DEC_WAIT:
					if (ready)
						state <= DEC_IDLE;

				default:
					state <= DEC_IDLE;
			endcase
		end
	end

	// The request is held here until the target has answered.
	always_ff @(posedge clk) begin
		if (state == DEC_IDLE && start) begin
			addr_q   <= addr;
			data_q   <= data_wr;
			write_q  <= write;
			region_q <= addr[29:28];
		end
	end

	assign ram_bus.addr    = addr_q;
	assign ram_bus.data_wr = data_q;
	assign ram_bus.write   = write_q;
	assign ram_bus.start   = issue && region_q == `PLAT_REGION_RAM;

	assign pio_bus.addr    = addr_q;
	assign pio_bus.data_wr = data_q;
	assign pio_bus.write   = write_q;
	assign pio_bus.start   = issue && region_q == `PLAT_REGION_PIO;

	assign tmr_bus.addr    = addr_q;
	assign tmr_bus.data_wr = data_q;
	assign tmr_bus.write   = write_q;
	assign tmr_bus.start   = issue && region_q == `PLAT_REGION_TIMER;

	always_comb begin
		data_rd = '0;
		ready   = 1'b0;

		if (state == DEC_WAIT) begin
			case (region_q)
				`PLAT_REGION_RAM: begin
					data_rd = ram_bus.data_rd;
					ready   = ram_bus.ready;
				end
				`PLAT_REGION_PIO: begin
					data_rd = pio_bus.data_rd;
					ready   = pio_bus.ready;
				end
				`PLAT_REGION_TIMER: begin
					data_rd = tmr_bus.data_rd;
					ready   = tmr_bus.ready;
				end
				default:
					ready = miss_ready;
			endcase
		end
	end

endmodule

//--- src/onchip_ram.sv
`timescale 1ns/100ps

`include "platform_config.svh"

module onchip_ram
	import platform_pkg::*;
(
	input  logic  clk,
	bus_if.target bus
);

	localparam int ram_addr_bits = $clog2(`PLAT_RAM_WORDS);

	word_t mem [`PLAT_RAM_WORDS];

	logic [ram_addr_bits-1:0] index;

	word_t rd_q;
	logic  pending;
	logic  ready_q;

	// Upper address bits inside the region are ignored, so they alias.
	assign index = bus.addr[ram_addr_bits-1:0];

	always_ff @(posedge clk) begin
		if (bus.start) begin
			if (bus.write)
				mem[index] <= bus.data_wr;
			else
				rd_q <= mem[index];
		end
	end

	// The access happens on the first edge and the answer goes out on the next.
	always_ff @(posedge clk) begin
		pending <= bus.start;
		ready_q <= pending;
	end

	assign bus.data_rd = rd_q;
	assign bus.ready   = ready_q;

endmodule

//--- src/pio_out.sv
`timescale 1ns/100ps

`include "platform_config.svh"

module pio_out
	import platform_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	bus_if.target bus,
	output led_t  leds
);

	reg_off_t offset;

	led_t  led_q;
	word_t rd_q;
	logic  ready_q;

	assign offset = bus.addr[1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			led_q   <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= bus.start;

			if (bus.start && bus.write) begin
				case (offset)
					`PIO_OFF_DATA: led_q <= bus.data_wr[7:0];
					`PIO_OFF_SET:  led_q <= led_q | bus.data_wr[7:0];
					`PIO_OFF_CLR:  led_q <= led_q & ~bus.data_wr[7:0];
					default:       led_q <= led_q;
				endcase
			end
		end
	end

	// Data, set and clear all read back the current LED value.
	always_ff @(posedge clk) begin
		if (bus.start && !bus.write) begin
			if (offset == `PIO_OFF_DATA || offset == `PIO_OFF_SET || offset == `PIO_OFF_CLR)
				rd_q <= {24'b0, led_q};
			else
				rd_q <= '0;
		end
	end

	assign bus.data_rd = rd_q;
	assign bus.ready   = ready_q;
	assign leds        = led_q;

endmodule

//--- src/interval_timer.sv
`timescale 1ns/100ps

`include "platform_config.svh"

module interval_timer
	import platform_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	bus_if.target bus,
	output logic  irq
);

	reg_off_t offset;

	word_t load_q;
	word_t count_q;
	logic  en_q;
	logic  irq_en_q;
	logic  expired_q;
	logic  irq_q;

	word_t rd_q;
	word_t rd_next;
	logic  ready_q;
	logic  wr;

	assign offset = bus.addr[1:0];
	assign wr     = bus.start && bus.write;

	always_ff @(posedge clk) begin
		if (rst) begin
			load_q    <= '0;
			count_q   <= '0;
			en_q      <= 1'b0;
			irq_en_q  <= 1'b0;
			expired_q <= 1'b0;
			irq_q     <= 1'b0;
			ready_q   <= 1'b0;
		end else begin
			ready_q <= bus.start;
			irq_q   <= expired_q && irq_en_q;

			if (wr && offset == `TMR_OFF_LOAD)
				load_q <= bus.data_wr;

			if (wr && offset == `TMR_OFF_STATUS && bus.data_wr[`TMR_STATUS_EXPIRED])
				expired_q <= 1'b0;

			if (wr && offset == `TMR_OFF_CTRL) begin
				en_q     <= bus.data_wr[`TMR_CTRL_EN];
				irq_en_q <= bus.data_wr[`TMR_CTRL_IRQ_EN];
				count_q  <= load_q;
			end else if (en_q) begin
				// Zero is a counted state, which gives a period of load+1 cycles.
				if (count_q == '0) begin
					count_q   <= load_q;
					expired_q <= 1'b1;
				end else begin
					count_q <= count_q - 1'b1;
				end
			end
		end
	end

	always_comb begin
		rd_next = '0;

		case (offset)
			`TMR_OFF_LOAD:   rd_next = load_q;
			`TMR_OFF_COUNT:  rd_next = count_q;
			`TMR_OFF_STATUS: rd_next[`TMR_STATUS_EXPIRED] = expired_q;
			default: begin
				rd_next[`TMR_CTRL_EN]     = en_q;
				rd_next[`TMR_CTRL_IRQ_EN] = irq_en_q;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus.start && !bus.write)
			rd_q <= rd_next;
	end

	assign bus.data_rd = rd_q;
	assign bus.ready   = ready_q;
	assign irq         = irq_q;

endmodule

//--- src/platform.sv
`timescale 1ns/100ps

module platform
	import platform_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  addr_t addr,
	input  word_t data_wr,
	input  logic  write,
	input  logic  start,
	output word_t data_rd,
	output logic  ready,
	output logic  irq,
	output led_t  pio_leds
);

	bus_if ram_bus ();
	bus_if pio_bus ();
	bus_if tmr_bus ();

	bus_decoder decoder
	(
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_wr(data_wr),
		.write(write),
		.start(start),
		.data_rd(data_rd),
		.ready(ready),
		.ram_bus(ram_bus.decoder),
		.pio_bus(pio_bus.decoder),
		.tmr_bus(tmr_bus.decoder)
	);

	onchip_ram ram
	(
		.clk(clk),
		.bus(ram_bus.target)
	);

	// The LED bits go straight to the board.
	pio_out pio
	(
		.clk(clk),
		.rst(rst),
		.bus(pio_bus.target),
		.leds(pio_leds)
	);

	interval_timer timer
	(
		.clk(clk),
		.rst(rst),
		.bus(tmr_bus.target),
		.irq(irq)
	);

endmodule

//--- tb/tb_platform.sv
`timescale 1ns/100ps

`include "platform_config.svh"

module tb_platform
	import platform_pkg::*;
();

	localparam int clk_period  = 8;
	localparam int ram_ops     = 200;
	localparam int pio_ops     = 60;
	localparam int max_latency = 3;
	localparam int ready_limit = 20;
	localparam int max_load    = 17;

	// Reset checks, RAM ops, five transfers per PIO op, then the unmapped and timer sequences.
	localparam int num_xfers = 2 + ram_ops + pio_ops * 5 + 40;
	localparam int timer_wait = 2 * (max_load + 5);
	// Each transfer also spends two cycles in the bus task around its latency.
	localparam int watchdog_cycles = 8 + num_xfers * (max_latency + 2) + timer_wait + 200;

	logic  clk;
	logic  rst;
	addr_t addr;
	word_t data_wr;
	logic  write;
	logic  start;
	word_t data_rd;
	logic  ready;
	logic  irq;
	led_t  pio_leds;

	int     errors;
	integer seed;

	word_t ram_model [int];
	int    written [$];
	led_t  led_model;
	word_t tmr_load;
	word_t tmr_ctrl;

	platform DUT (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.data_wr(data_wr),
		.write(write),
		.start(start),
		.data_rd(data_rd),
		.ready(ready),
		.irq(irq),
		.pio_leds(pio_leds)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired, the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	function automatic addr_t reg_addr(input logic [1:0] region, input reg_off_t off);
		reg_addr = {region, 26'b0, off};
	endfunction

	// Only the low part of a RAM address picks the word, so upper bits alias.
	function automatic int ram_index(input addr_t a);
		ram_index = int'(a[27:0]) % `PLAT_RAM_WORDS;
	endfunction

	task automatic wait_ready(input string what, input addr_t a);
		int cycles;
		cycles = 0;
		while (!ready && cycles < ready_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!ready) begin
			errors++;
			$display("No ready for %s at address %h within %0d cycles", what, a, ready_limit);
		end
	endtask

	task automatic bus_write(input addr_t a, input word_t d);
		@(negedge clk);
		addr    = a;
		data_wr = d;
		write   = 1'b1;
		start   = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_ready("write", a);
	endtask

	task automatic bus_read(input addr_t a, output word_t d);
		@(negedge clk);
		addr  = a;
		write = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_ready("read", a);
		d = data_rd;
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_led(input string name, input led_t expected, input led_t actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	initial begin
		int       i;
		int       k;
		int       idx;
		int       load_val;
		reg_off_t off;
		addr_t    a;
		word_t    d;
		word_t    rd;
		word_t    expired_word;

		seed      = 32'h4bce_3513;
		errors    = 0;
		rst       = 1'b1;
		addr      = '0;
		data_wr   = '0;
		write     = 1'b0;
		start     = 1'b0;
		led_model = '0;
		tmr_load  = '0;
		tmr_ctrl  = '0;
		expired_word = '0;
		expired_word[`TMR_STATUS_EXPIRED] = 1'b1;

		repeat (8) @(negedge clk);
		rst = 1'b0;

		check_led("reset leds", '0, pio_leds);
		check_bit("reset irq", 1'b0, irq);
		check_bit("reset ready", 1'b0, ready);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), rd);
		check_word("reset timer ctrl", '0, rd);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), rd);
		check_word("reset timer status", '0, rd);

		// Reads only go to words that were written, since the RAM is not reset.
		for (i = 0; i < ram_ops; i++) begin
			a = $random(seed);
			a[29:28] = `PLAT_REGION_RAM;
			if (written.size() == 0 || ($random(seed) & 1)) begin
				d = $random(seed);
				bus_write(a, d);
				idx = ram_index(a);
				if (!ram_model.exists(idx))
					written.push_back(idx);
				ram_model[idx] = d;
			end else begin
				k = $unsigned($random(seed)) % written.size();
				idx = written[k];
				a[27:0] = a[27:0] - ram_index(a) + idx;
				bus_read(a, rd);
				check_word("ram read", ram_model[idx], rd);
			end
		end

		for (i = 0; i < pio_ops; i++) begin
			off = $random(seed);
			d = $random(seed);
			a = $random(seed);
			a[29:28] = `PLAT_REGION_PIO;
			a[1:0] = off;
			bus_write(a, d);
			case (off)
				`PIO_OFF_DATA: led_model = d[7:0];
				`PIO_OFF_SET:  led_model = led_model | d[7:0];
				`PIO_OFF_CLR:  led_model = led_model & ~d[7:0];
				default:       led_model = led_model;
			endcase
			check_led("pio leds", led_model, pio_leds);
			for (k = 0; k < 4; k++) begin
				a[1:0] = reg_off_t'(k);
				bus_read(a, rd);
				if (k == 3)
					check_word("pio offset 3 read", '0, rd);
				else
					check_word("pio read", {24'b0, led_model}, rd);
			end
		end

		a = $random(seed);
		a[29:28] = 2'd3;
		bus_read(a, rd);
		check_word("unmapped read", '0, rd);
		// These writes alias a written RAM word and every register offset.
		idx = written[0];
		a[27:0] = a[27:0] - ram_index(a) + idx;
		bus_write(a, ~ram_model[idx]);
		for (k = 0; k < 4; k++) begin
			a = $random(seed);
			a[29:28] = 2'd3;
			a[1:0] = reg_off_t'(k);
			bus_write(a, 32'hffff_ffff);
		end
		a = addr_t'(idx);
		a[29:28] = `PLAT_REGION_RAM;
		bus_read(a, rd);
		check_word("ram after unmapped write", ram_model[idx], rd);
		check_led("leds after unmapped write", led_model, pio_leds);
		bus_read(reg_addr(`PLAT_REGION_PIO, `PIO_OFF_DATA), rd);
		check_word("pio after unmapped write", {24'b0, led_model}, rd);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_LOAD), rd);
		check_word("timer load after unmapped write", tmr_load, rd);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), rd);
		check_word("timer ctrl after unmapped write", tmr_ctrl, rd);
		check_bit("irq after unmapped write", 1'b0, irq);

		load_val = ($random(seed) & 15) + 2;
		tmr_load = word_t'(load_val);
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_LOAD), tmr_load);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_LOAD), rd);
		check_word("timer load read", tmr_load, rd);
		tmr_ctrl = '0;
		tmr_ctrl[`TMR_CTRL_EN] = 1'b1;
		tmr_ctrl[`TMR_CTRL_IRQ_EN] = 1'b1;
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), tmr_ctrl);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), rd);
		check_word("timer ctrl read", tmr_ctrl, rd);
		repeat (load_val + 4) @(negedge clk);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), rd);
		check_word("timer expired status", expired_word, rd);
		check_bit("timer irq raised", 1'b1, irq);

		// Stopping the count keeps the timer from expiring again before the clear is seen.
		tmr_ctrl = '0;
		tmr_ctrl[`TMR_CTRL_IRQ_EN] = 1'b1;
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), tmr_ctrl);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_COUNT), rd);
		check_word("timer count after reload", tmr_load, rd);
		check_bit("timer irq held", 1'b1, irq);
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), expired_word);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), rd);
		check_word("timer status cleared", '0, rd);
		check_bit("timer irq cleared", 1'b0, irq);

		tmr_ctrl = '0;
		tmr_ctrl[`TMR_CTRL_EN] = 1'b1;
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), tmr_ctrl);
		repeat (load_val + 4) @(negedge clk);
		check_bit("timer irq masked", 1'b0, irq);
		bus_read(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), rd);
		check_word("timer masked status", expired_word, rd);
		check_bit("timer irq still masked", 1'b0, irq);
		tmr_ctrl = '0;
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_CTRL), tmr_ctrl);
		bus_write(reg_addr(`PLAT_REGION_TIMER, `TMR_OFF_STATUS), expired_word);

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
src/platform_pkg.sv
src/bus_if.sv
src/bus_decoder.sv
src/onchip_ram.sv
src/pio_out.sv
src/interval_timer.sv
src/platform.sv
tb/tb_platform.sv
